// File: vlog.f
+incdir+verilog
verilog/cam_filter_pkg.sv
verilog/ir_command_decoder.sv
verilog/pixel_luma_stage.sv
verilog/mode_output_mux.sv
verilog/cam_filter_top.sv
tests/cam_filter_assert.sv
tests/cam_filter_checker.sv
tests/cam_filter_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, check the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module cam_filter_tb \
    -Mdir obj_dir -o cam_filter_sim -f vlog.f

./obj_dir/cam_filter_sim | tee sim.log

if grep -q "^all tests passed$" sim.log; then
    echo "result: PASS"
    exit 0
fi
echo "result: FAIL"
exit 1

// File: tests/cam_filter_tb.sv
`include "cam_filter_defs.svh"

module cam_filter_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import cam_filter_pkg::*;

    localparam int WAIT_LIMIT = 200;   // cycles allowed per wait

    logic               clk_25_vga;
    logic               reset;
    logic               key_valid;
    logic [`KEY_W-1:0]  key_code;
    logic               pix_valid;
    logic               pix_ready;
    rgb565_word_t       pix_word;
    logic               pix_active;
    logic               out_valid;
    logic               out_ready;
    logic [`CHAN_W-1:0] out_r;
    logic [`CHAN_W-1:0] out_g;
    logic [`CHAN_W-1:0] out_b;
    int                 error_count;
    int                 pending_count;
    int                 checked_count;
    logic               stall_on;
    logic               timed_out;
    int                 errors_before;
    int                 tests_ok;
    int                 tests_bad;

    cam_filter_top DUT (.*);

    cam_filter_checker u_checker (.*);

    bind cam_filter_top cam_filter_assert u_assert (
        .clk_25_vga (clk_25_vga),
        .reset      (reset),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_r      (out_r),
        .out_g      (out_g),
        .out_b      (out_b)
    );

    initial begin
        clk_25_vga = 1'b0;
        forever #50 clk_25_vga = ~clk_25_vga;
    end

    // vga sink, stalls at random only while stall_on is set
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clk_25_vga);
            #10;
            out_ready = stall_on ? ($urandom_range(3) != 0) : 1'b1;
        end
    end

    // ============================================================
    // stimulus tasks, all start and end 10 ns after an edge
    // ============================================================
    task automatic next_cycle();
        @(posedge clk_25_vga);
        #10;
    endtask

    task automatic send_key(input logic [`KEY_W-1:0] code);
        key_valid = 1'b1;
        key_code  = code;
        next_cycle();
        key_valid = 1'b0;
    endtask

    task automatic send_pixel(input logic [`PIXEL_W-1:0] word, input logic active);
        int waited;
        waited     = 0;
        pix_valid  = 1'b1;
        pix_word   = word;
        pix_active = active;
        @(negedge clk_25_vga);
        while (!pix_ready && !timed_out) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: pix_ready stayed low for %0d cycles", WAIT_LIMIT);
                timed_out = 1'b1;
            end
            @(negedge clk_25_vga);
        end
        next_cycle();
        pix_valid = 1'b0;
    endtask

    task automatic send_random(input int count, input logic active);
        repeat (count) send_pixel(16'($urandom), active);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk_25_vga);
        while (pending_count != 0 && !timed_out) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: %0d pixels never left the pipeline", pending_count);
                timed_out = 1'b1;
            end
            @(negedge clk_25_vga);
        end
        next_cycle();
    endtask

    task automatic send_mixed(input int count);
        repeat (count) send_pixel(16'($urandom), 1'($urandom));   // blanking mixed in
        wait_drain();
    endtask

    task automatic end_test(input int num, input string name);
        stall_on = 1'b0;
        wait_drain();
        if (!timed_out && error_count == errors_before) begin
            tests_ok++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: FAIL, %0d new mismatches", num, name,
                     error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        void'($urandom(32'h1d5d));
        reset         = 1'b1;
        key_valid     = 1'b0;
        key_code      = '0;
        pix_valid     = 1'b0;
        pix_word      = '0;
        pix_active    = 1'b0;
        stall_on      = 1'b0;
        timed_out     = 1'b0;
        errors_before = 0;
        tests_ok      = 0;
        tests_bad     = 0;
        repeat (3) @(posedge clk_25_vga);
        #10;
        reset = 1'b0;

        send_random(20, 1'b1);
        end_test(1, "original colour");

        send_key(`KEY_A);
        send_random(20, 1'b1);
        end_test(2, "grey");

        send_key(`KEY_B);
        send_random(20, 1'b1);
        wait_drain();
        repeat (40) send_key(`KEY_UP);      // clips at 255
        send_pixel(16'hFFFF, 1'b1);         // luma 251, dark at 255
        wait_drain();
        send_key(`KEY_DOWN);                // 250
        send_pixel(16'hFFFF, 1'b1);
        wait_drain();
        repeat (60) send_key(`KEY_DOWN);    // clips at 0
        send_pixel(16'h0000, 1'b1);         // luma 4, bright at 0
        wait_drain();
        send_key(`KEY_UP);                  // 5
        send_pixel(16'h0000, 1'b1);
        end_test(3, "binary threshold");

        send_key(`KEY_ORIG);
        send_mixed(12);
        send_key(`KEY_A);
        send_mixed(12);
        send_key(`KEY_B);
        send_mixed(12);
        send_key(8'h55);                    // not on the remote map
        send_key(8'h00);
        send_key(8'hFF);
        send_mixed(12);
        end_test(4, "blanking and unknown keys");

        send_key(`KEY_ORIG);
        stall_on = 1'b1;
        repeat (200) begin
            repeat ($urandom_range(2)) next_cycle();
            send_pixel(16'($urandom), 1'b1);
        end
        end_test(5, "back-pressure");

        $display("summary: %0d tests ok, %0d failing, %0d pixels checked, %0d mismatches",
                 tests_ok, tests_bad, checked_count, error_count);
        if (tests_bad == 0 && error_count == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: tests/cam_filter_checker.sv
`include "cam_filter_defs.svh"

module cam_filter_checker (
    input  logic                         clk_25_vga,
    input  logic                         reset,
    input  logic                         key_valid,
    input  logic [`KEY_W-1:0]            key_code,
    input  logic                         pix_valid,
    input  logic                         pix_ready,
    input  cam_filter_pkg::rgb565_word_t pix_word,
    input  logic                         pix_active,
    input  logic                         out_valid,
    input  logic                         out_ready,
    input  logic [`CHAN_W-1:0]           out_r,
    input  logic [`CHAN_W-1:0]           out_g,
    input  logic [`CHAN_W-1:0]           out_b,
    output int                           error_count,
    output int                           pending_count,
    output int                           checked_count
);

    timeunit 1ns;
    timeprecision 1ps;

    import cam_filter_pkg::*;

    logic [`MODE_W-1:0] mode;         // mirrored display mode
    int                 thr;          // mirrored threshold
    logic [23:0]        expect_q[$];  // {r, g, b} per accepted pixel
    logic [23:0]        head;

    // reference colour, straight from the rgb565 and luma rules
    function automatic logic [23:0] expected_colour(input logic [`MODE_W-1:0] m,
                                                    input int t,
                                                    input rgb565_word_t w,
                                                    input logic active);
        int r8;
        int g8;
        int b8;
        int luma;
        logic [7:0] bin;
        r8   = int'(w.rgb.red) * 8 + 7;     // low bits filled with ones
        g8   = int'(w.rgb.green) * 4 + 3;
        b8   = int'(w.rgb.blue) * 8 + 7;
        luma = (r8 * 76 + g8 * 150 + b8 * 26) / 256;
        bin  = (luma >= t) ? 8'hFF : 8'h00;
        if (!active) begin
            return 24'h000000;
        end else if (m == `MODE_GRAY) begin
            return {8'(luma), 8'(luma), 8'(luma)};
        end else if (m == `MODE_BINARY) begin
            return {bin, bin, bin};
        end
        return {8'(r8), 8'(g8), 8'(b8)};
    endfunction

    function automatic void compare_chan(input string name, input logic [7:0] want,
                                         input logic [7:0] got);
        if (got !== want) begin
            error_count++;
            $display("CHECK FAILED %s: expected %02h, got %02h at %0t", name, want, got, $time);
        end
    endfunction

    // ============================================================
    // monitor
    // ============================================================
    always @(posedge clk_25_vga) begin
        if (reset) begin
            mode = `MODE_ORIG;
            thr  = int'(`THR_RESET);
            expect_q.delete();
        end else begin
            if (out_valid && out_ready) begin
                if (expect_q.size() == 0) begin
                    error_count++;
                    $display("output pixel came out with no accepted input pending at %0t", $time);
                end else begin
                    head = expect_q.pop_front();
                    checked_count++;
                    compare_chan("out_r", head[23:16], out_r);
                    compare_chan("out_g", head[15:8], out_g);
                    compare_chan("out_b", head[7:0], out_b);
                end
            end
            if (pix_valid && pix_ready) begin
                expect_q.push_back(expected_colour(mode, thr, pix_word, pix_active));
            end
            if (key_valid) begin
                case (key_code)
                    `KEY_ORIG: mode = `MODE_ORIG;
                    `KEY_A:    mode = `MODE_GRAY;
                    `KEY_B:    mode = `MODE_BINARY;
                    `KEY_UP:   thr = (thr + int'(`THR_STEP) > 255) ? 255 : thr + int'(`THR_STEP);
                    `KEY_DOWN: thr = (thr - int'(`THR_STEP) < 0) ? 0 : thr - int'(`THR_STEP);
                    default:   ;   // unknown keys do nothing
                endcase
            end
        end
        pending_count = expect_q.size();
    end

endmodule

// File: tests/cam_filter_assert.sv
`include "cam_filter_defs.svh"

module cam_filter_assert (
    input  logic               clk_25_vga,
    input  logic               reset,
    input  logic               out_valid,
    input  logic               out_ready,
    input  logic [`CHAN_W-1:0] out_r,
    input  logic [`CHAN_W-1:0] out_g,
    input  logic [`CHAN_W-1:0] out_b
);

    timeunit 1ns;
    timeprecision 1ps;

    // pipeline comes out of reset empty
    a_reset_idle: assert property (@(posedge clk_25_vga) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // vga sink stalled, colour must hold
    a_hold_data: assert property (@(posedge clk_25_vga) disable iff (reset)
        (out_valid && !out_ready) |=> ($stable(out_r) && $stable(out_g) && $stable(out_b)))
        else $error("output colour changed while out_ready was low");

    a_hold_valid: assert property (@(posedge clk_25_vga) disable iff (reset)
        (out_valid && !out_ready) |=> out_valid)   // no pixel dropped
        else $error("out_valid fell without a transfer");

endmodule

// File: verilog/cam_filter_top.sv
`include "cam_filter_defs.svh"

module cam_filter_top (
    input  logic                         clk_25_vga,
    input  logic                         reset,

    // decoded ir commands
    input  logic                         key_valid,
    input  logic [`KEY_W-1:0]            key_code,

    // frame-buffer pixel stream
    input  logic                         pix_valid,
    output logic                         pix_ready,
    input  cam_filter_pkg::rgb565_word_t pix_word,
    input  logic                         pix_active,

    // vga pixel stream
    output logic                         out_valid,
    input  logic                         out_ready,
    output logic [`CHAN_W-1:0]           out_r,
    output logic [`CHAN_W-1:0]           out_g,
    output logic [`CHAN_W-1:0]           out_b
);

    import cam_filter_pkg::*;

    // ============================================================
    // internal nets
    // ============================================================
    logic [`MODE_W-1:0]  disp_mode;
    logic [`CHAN_W-1:0]  threshold;

    logic                s1_valid;
    logic                s1_ready;
    rgb565_word_t        s1_rgb565;
    logic [`CHAN_W-1:0]  s1_luma;
    logic                s1_active;

    ir_command_decoder u_ir_dec (
        .clk_25_vga (clk_25_vga),
        .reset      (reset),
        .key_valid  (key_valid),
        .key_code   (key_code),
        .disp_mode  (disp_mode),
        .threshold  (threshold)
    );

    // stage 1 expands rgb565 and computes luma
    pixel_luma_stage u_luma (
        .clk_25_vga (clk_25_vga),
        .reset      (reset),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .pix_word   (pix_word),
        .pix_active (pix_active),
        .s1_valid   (s1_valid),
        .s1_ready   (s1_ready),
        .s1_rgb565  (s1_rgb565),
        .s1_luma    (s1_luma),
        .s1_active  (s1_active)
    );

    // stage 2 picks the colour per mode
    mode_output_mux u_mux (
        .clk_25_vga (clk_25_vga),
        .reset      (reset),
        .s1_valid   (s1_valid),
        .s1_ready   (s1_ready),
        .s1_rgb565  (s1_rgb565),
        .s1_luma    (s1_luma),
        .s1_active  (s1_active),
        .disp_mode  (disp_mode),
        .threshold  (threshold),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_r      (out_r),
        .out_g      (out_g),
        .out_b      (out_b)
    );

endmodule

// File: verilog/mode_output_mux.sv
`include "cam_filter_defs.svh"

module mode_output_mux (
    input  logic                         clk_25_vga,
    input  logic                         reset,

    // from the luma stage
    input  logic                         s1_valid,
    output logic                         s1_ready,
    input  cam_filter_pkg::rgb565_word_t s1_rgb565,
    input  logic [`CHAN_W-1:0]           s1_luma,
    input  logic                         s1_active,

    // ir controls
    input  logic [`MODE_W-1:0]           disp_mode,
    input  logic [`CHAN_W-1:0]           threshold,

    // vga sink
    output logic                         out_valid,
    input  logic                         out_ready,
    output logic [`CHAN_W-1:0]           out_r,
    output logic [`CHAN_W-1:0]           out_g,
    output logic [`CHAN_W-1:0]           out_b
);

    // ============================================================
    // colour select
    // ============================================================
    logic [`CHAN_W-1:0] orig_r;
    logic [`CHAN_W-1:0] orig_g;
    logic [`CHAN_W-1:0] orig_b;
    logic [`CHAN_W-1:0] bin_val;
    logic [`CHAN_W-1:0] next_r;
    logic [`CHAN_W-1:0] next_g;
    logic [`CHAN_W-1:0] next_b;

    assign orig_r = {s1_rgb565.rgb.red,   3'b111};
    assign orig_g = {s1_rgb565.rgb.green, 2'b11};
    assign orig_b = {s1_rgb565.rgb.blue,  3'b111};

    assign bin_val = (s1_luma >= threshold) ? 8'hFF : 8'h00;

    always_comb begin
        if (!s1_active) begin
            next_r = '0;    // blanking is black in every mode
            next_g = '0;
            next_b = '0;
        end else begin
            case (disp_mode)
                `MODE_GRAY: begin
                    next_r = s1_luma;
                    next_g = s1_luma;
                    next_b = s1_luma;
                end
                `MODE_BINARY: begin
                    next_r = bin_val;
                    next_g = bin_val;
                    next_b = bin_val;
                end
                default: begin    // MODE_ORIG and the unused code
                    next_r = orig_r;
                    next_g = orig_g;
                    next_b = orig_b;
                end
            endcase
        end
    end

    // ============================================================
    // output register
    // ============================================================
    logic take;

    assign s1_ready = ~out_valid | out_ready;
    assign take     = s1_valid & s1_ready;

    always_ff @(posedge clk_25_vga) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // colour held while the sink stalls
    always_ff @(posedge clk_25_vga) begin
        if (take) begin
            out_r <= next_r;
            out_g <= next_g;
            out_b <= next_b;
        end
    end

endmodule

// File: verilog/pixel_luma_stage.sv
`include "cam_filter_defs.svh"

module pixel_luma_stage (
    input  logic                         clk_25_vga,
    input  logic                         reset,

    // frame-buffer read side
    input  logic                         pix_valid,
    output logic                         pix_ready,
    input  cam_filter_pkg::rgb565_word_t pix_word,
    input  logic                         pix_active,   // low during blanking

    // towards the output mux
    output logic                         s1_valid,
    input  logic                         s1_ready,
    output cam_filter_pkg::rgb565_word_t s1_rgb565,
    output logic [`CHAN_W-1:0]           s1_luma,
    output logic                         s1_active
);

    // ============================================================
    // rgb565 to rgb888
    // ============================================================
    logic [`CHAN_W-1:0] r_888;
    logic [`CHAN_W-1:0] g_888;
    logic [`CHAN_W-1:0] b_888;

    // missing low bits filled with ones, so full scale stays ffh
    assign r_888 = {pix_word.rgb.red,   3'b111};
    assign g_888 = {pix_word.rgb.green, 2'b11};
    assign b_888 = {pix_word.rgb.blue,  3'b111};

    // ============================================================
    // luma, 76 r + 150 g + 26 b
    // ============================================================
    logic [16:0] r_ext;
    logic [16:0] g_ext;
    logic [16:0] b_ext;
    logic [16:0] gray_sum;
    logic [`CHAN_W-1:0] luma_next;

    assign r_ext = {9'd0, r_888};
    assign g_ext = {9'd0, g_888};
    assign b_ext = {9'd0, b_888};

    assign gray_sum = (r_ext << 6) + (r_ext << 3) + (r_ext << 2)   // 64+8+4
                    + (g_ext << 7) + (g_ext << 4) + (g_ext << 2)   // 128+16+4
                    + (g_ext << 1)                                 // +2
                    + (b_ext << 4) + (b_ext << 3) + (b_ext << 1);  // 16+8+2

    // weights add up to 252, so bit 16 never sets and the
    // upper byte is bits 15:8
    assign luma_next = pix_active ? gray_sum[15:8] : '0;

    // ============================================================
    // stage register
    // ============================================================
    logic take;

    // empty, or the held pixel leaves this cycle
    assign pix_ready = ~s1_valid | s1_ready;
    assign take      = pix_valid & pix_ready;

    always_ff @(posedge clk_25_vga) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else if (take) begin
            s1_valid <= 1'b1;
        end else if (s1_ready) begin
            s1_valid <= 1'b0;    // drained, nothing new
        end
    end

    // payload only moves on acceptance
    always_ff @(posedge clk_25_vga) begin
        if (take) begin
            s1_rgb565 <= pix_word;
            s1_luma   <= luma_next;
            s1_active <= pix_active;
        end
    end

endmodule

// File: verilog/ir_command_decoder.sv
`include "cam_filter_defs.svh"

module ir_command_decoder (
    input  logic                clk_25_vga,
    input  logic                reset,
    input  logic                key_valid,    // one cycle per decoded key
    input  logic [`KEY_W-1:0]   key_code,
    output logic [`MODE_W-1:0]  disp_mode,
    output logic [`CHAN_W-1:0]  threshold
);

    // ============================================================
    // threshold limits
    // ============================================================
    localparam logic [`CHAN_W-1:0] THR_MAX = '1;
    localparam logic [`CHAN_W-1:0] THR_MIN = '0;

    logic [`CHAN_W-1:0] thr_up;     // next value for KEY_UP
    logic [`CHAN_W-1:0] thr_down;   // next value for KEY_DOWN

    // saturating steps, computed up front so the
    // register block below stays a plain case
    always_comb begin
        if (threshold >= THR_MAX - `THR_STEP) begin
            thr_up = THR_MAX;
        end else begin
            thr_up = threshold + `THR_STEP;
        end

        if (threshold <= THR_MIN + `THR_STEP) begin
            thr_down = THR_MIN;
        end else begin
            thr_down = threshold - `THR_STEP;
        end
    end

    // ============================================================
    // command register
    // ============================================================
    always_ff @(posedge clk_25_vga) begin
        if (reset) begin
            disp_mode <= `MODE_ORIG;
            threshold <= `THR_RESET;
        end else if (key_valid) begin
            case (key_code)
                `KEY_ORIG: begin
                    disp_mode <= `MODE_ORIG;
                end
                `KEY_A: begin
                    disp_mode <= `MODE_GRAY;
                end
                `KEY_B: begin
                    disp_mode <= `MODE_BINARY;
                end
                `KEY_UP: begin
                    threshold <= thr_up;
                end
                `KEY_DOWN: begin
                    threshold <= thr_down;
                end
                default: begin
                    // other remote keys have no function here
                end
            endcase
        end
    end

endmodule

// File: verilog/cam_filter_pkg.sv
`include "cam_filter_defs.svh"

package cam_filter_pkg;

    // ============================================================
    // frame-buffer pixel word
    // ============================================================

    // the ram hands back one 16 bit word per pixel
    // expansion and luma need the colour fields,
    // while the pipeline registers just move the raw word
    typedef union packed {
        logic [`PIXEL_W-1:0] raw;   // word as read from the ram

        struct packed {
            logic [4:0] red;        // bits 15:11
            logic [5:0] green;      // bits 10:5
            logic [4:0] blue;       // bits 4:0
        } rgb;
    } rgb565_word_t;

    // green has one bit more than red and blue, which is
    // why the expansion pads it with two ones and not three

endpackage

// File: verilog/cam_filter_defs.svh
`ifndef CAM_FILTER_DEFS_SVH
`define CAM_FILTER_DEFS_SVH

// ============================================================
// widths
// ============================================================
`define PIXEL_W 16   // rgb565 frame-buffer word
`define CHAN_W  8    // one vga colour channel
`define KEY_W   8    // decoded ir key code
`define MODE_W  2    // display mode code

// ============================================================
// display modes
// ============================================================
`define MODE_ORIG   2'd0
`define MODE_GRAY   2'd1
`define MODE_BINARY 2'd2

// ============================================================
// ir key codes (remote layout)
// ============================================================
`define KEY_ORIG 8'h12   // back to camera colour
`define KEY_A    8'h0F   // grey
`define KEY_B    8'h13   // binary threshold
`define KEY_UP   8'h1A
`define KEY_DOWN 8'h1E

// threshold control
`define THR_RESET 8'd64
`define THR_STEP  8'd5

`endif
